/* source/isa_pkg.sv */
`default_nettype none

package isa_pkg;

    // architectural data word, also used for pc and immediates
    typedef logic [31:0] word_t;

    // register file index, 32 architectural registers
    typedef logic [4:0] reg_addr_t;

    // coarse operation class as decode sees it
    typedef enum logic [3:0] {
        OP_ALU       = 4'd0,
        OP_MULDIV    = 4'd1,
        OP_LOAD      = 4'd2,
        OP_STORE     = 4'd3,
        OP_BRANCH    = 4'd4,
        OP_JUMP      = 4'd5,
        OP_EXCEPTION = 4'd6,
        OP_ERET      = 4'd7,
        OP_MFHI      = 4'd8,
        OP_MFLO      = 4'd9,
        OP_MTHI      = 4'd10,
        OP_MTLO      = 4'd11
    } op_class_t;

    // control flags carried with each instruction
    // serial marks exception and eret, they never share an issue cycle
    typedef struct packed {
        op_class_t op;
        logic      regwrite;
        logic      branch;
        logic      jump;
        logic      muldiv;
        logic      hiwrite;
        logic      lowrite;
        logic      hiread;
        logic      loread;
        logic      serial;
    } ctl_t;

endpackage

`default_nettype wire

/* source/issue_pkg.sv */
`default_nettype none

package issue_pkg;

    // one decoded instruction as it sits in the queue
    typedef struct packed {
        logic              valid;
        isa_pkg::word_t    pc;
        isa_pkg::word_t    imm;
        isa_pkg::ctl_t     ctl;
        isa_pkg::reg_addr_t rdst;
        isa_pkg::reg_addr_t ra1;
        isa_pkg::reg_addr_t ra2;
    } dec_entry_t;

    // element 1 older, element 0 valid only with element 1
    typedef dec_entry_t [1:0] dec_pair_t;

    // issued instruction with its operand values
    typedef struct packed {
        logic              valid;
        isa_pkg::word_t    pc;
        isa_pkg::word_t    imm;
        isa_pkg::ctl_t     ctl;
        isa_pkg::reg_addr_t rdst;
        isa_pkg::reg_addr_t ra1;
        isa_pkg::reg_addr_t ra2;
        isa_pkg::word_t    rd1;
        isa_pkg::word_t    rd2;
        // delay slot of a branch or jump in the older slot
        logic              is_slot;
    } iss_entry_t;

    // element 1 is the older slot
    typedef iss_entry_t [1:0] iss_pair_t;

    // one source operand from the bypass network
    typedef struct packed {
        logic           ready;
        logic           bypass;
        isa_pkg::word_t data;
    } operand_t;

    // everything the environment returns for one slot
    typedef struct packed {
        operand_t       op1;
        operand_t       op2;
        isa_pkg::word_t rd1;
        isa_pkg::word_t rd2;
    } slot_operands_t;

    // register lookup request of one candidate
    typedef struct packed {
        isa_pkg::reg_addr_t ra1;
        isa_pkg::reg_addr_t ra2;
    } src_req_t;

endpackage

`default_nettype wire

/* source/issue_bank.sv */
`default_nettype none

module issue_bank #(
    parameter int QUEUE_DEPTH = 16,
    localparam int ADDR_W = $clog2(QUEUE_DEPTH)
) (
    input  logic                  clk,
    input  logic                  wr_en,
    input  logic [ADDR_W-1:0]     wr_addr,
    input  issue_pkg::dec_entry_t wr_data,
    input  logic [ADDR_W-1:0]     rd_addr,
    output issue_pkg::dec_entry_t rd_data
);

    // entry storage
    // occupancy lives in the control pointers
    issue_pkg::dec_entry_t mem [QUEUE_DEPTH];

    // write lands at the edge
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // head entry seen in the same cycle
    assign rd_data = mem[rd_addr];

endmodule

`default_nettype wire

/* source/issue_control.sv */
`default_nettype none

module issue_control #(
    parameter int QUEUE_DEPTH = 16,
    localparam int ADDR_W = $clog2(QUEUE_DEPTH)
) (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  flush,
    input  issue_pkg::dec_pair_t  dec,
    output logic                  dec_ready,
    input  logic                  iss_ready,
    input  logic                  issue_old,
    input  logic                  issue_young,
    output logic                  wr_en_even,
    output logic                  wr_en_odd,
    output issue_pkg::dec_entry_t wr_data_even,
    output issue_pkg::dec_entry_t wr_data_odd,
    output logic [ADDR_W-1:0]     wr_addr_even,
    output logic [ADDR_W-1:0]     wr_addr_odd,
    output logic [ADDR_W-1:0]     rd_addr_even,
    output logic [ADDR_W-1:0]     rd_addr_odd,
    output logic                  older_odd,
    output logic                  not_empty_even,
    output logic                  not_empty_odd
);

    // one extra wrap bit so a full bank differs from an empty one
    logic [ADDR_W:0] head_even;
    logic [ADDR_W:0] head_odd;
    logic [ADDR_W:0] tail_even;
    logic [ADDR_W:0] tail_odd;
    logic [ADDR_W:0] used_even;
    logic [ADDR_W:0] used_odd;
    logic            tails_equal;
    logic            pop_even;
    logic            pop_odd;

    // occupancy per bank
    assign used_even = tail_even - head_even;
    assign used_odd  = tail_odd - head_odd;

    // stop decode with one slot of margin left in either bank
    assign dec_ready = (used_even < (ADDR_W + 1)'(QUEUE_DEPTH - 1))
                    && (used_odd < (ADDR_W + 1)'(QUEUE_DEPTH - 1));

    // tails equal means the odd bank takes the next older entry
    assign tails_equal  = tail_odd == tail_even;
    assign wr_data_odd  = tails_equal ? dec[1] : dec[0];
    assign wr_data_even = tails_equal ? dec[0] : dec[1];
    assign wr_en_odd    = dec_ready && wr_data_odd.valid;
    assign wr_en_even   = dec_ready && wr_data_even.valid;
    assign wr_addr_odd  = tail_odd[ADDR_W-1:0];
    assign wr_addr_even = tail_even[ADDR_W-1:0];

    // heads equal means the odd bank holds the older candidate
    assign older_odd      = head_odd == head_even;
    assign not_empty_even = head_even != tail_even;
    assign not_empty_odd  = head_odd != tail_odd;
    assign rd_addr_even   = head_even[ADDR_W-1:0];
    assign rd_addr_odd    = head_odd[ADDR_W-1:0];

    // one pop per issued slot, taken from the bank that holds it
    assign pop_odd  = iss_ready && (older_odd ? issue_old : issue_young);
    assign pop_even = iss_ready && (older_odd ? issue_young : issue_old);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            head_even <= '0;
            head_odd  <= '0;
            tail_even <= '0;
            tail_odd  <= '0;
        end else if (flush) begin
            // flush wins over enqueue and dequeue
            head_even <= '0;
            head_odd  <= '0;
            tail_even <= '0;
            tail_odd  <= '0;
        end else begin
            if (wr_en_even) begin
                tail_even <= tail_even + 1'b1;
            end
            if (wr_en_odd) begin
                tail_odd <= tail_odd + 1'b1;
            end
            if (pop_even) begin
                head_even <= head_even + 1'b1;
            end
            if (pop_odd) begin
                head_odd <= head_odd + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* source/issue_slots.sv */
`default_nettype none

module issue_slots (
    input  issue_pkg::dec_entry_t          rd_data_even,
    input  issue_pkg::dec_entry_t          rd_data_odd,
    input  logic                           older_odd,
    input  logic                           not_empty_even,
    input  logic                           not_empty_odd,
    input  logic                           issue_old,
    input  logic                           issue_young,
    input  issue_pkg::slot_operands_t [1:0] ops,
    output issue_pkg::dec_pair_t           candidates,
    output issue_pkg::src_req_t [1:0]      src,
    output issue_pkg::iss_pair_t           iss
);

    issue_pkg::dec_entry_t even_cand;
    issue_pkg::dec_entry_t odd_cand;
    logic [1:0]            issue_en;
    logic                  old_is_ctrl;

    // operand value, bypass data wins over the register file word
    function automatic isa_pkg::word_t pick(issue_pkg::operand_t op, isa_pkg::word_t rf);
        return op.bypass ? op.data : rf;
    endfunction

    // empty bank shows no candidate
    assign even_cand = not_empty_even ? rd_data_even : '0;
    assign odd_cand  = not_empty_odd ? rd_data_odd : '0;

    // older into element 1
    assign candidates[1] = older_odd ? odd_cand : even_cand;
    assign candidates[0] = older_odd ? even_cand : odd_cand;

    // register lookups follow the candidates
    always_comb begin
        for (int i = 0; i < 2; i++) begin
            src[i].ra1 = candidates[i].ra1;
            src[i].ra2 = candidates[i].ra2;
        end
    end

    assign issue_en    = {issue_old, issue_young};
    assign old_is_ctrl = candidates[1].ctl.branch || candidates[1].ctl.jump;

    always_comb begin
        iss = '0;
        for (int i = 0; i < 2; i++) begin
            // slot left invalid unless it issues
            if (issue_en[i]) begin
                iss[i].valid = candidates[i].valid;
                iss[i].pc    = candidates[i].pc;
                iss[i].imm   = candidates[i].imm;
                iss[i].ctl   = candidates[i].ctl;
                iss[i].rdst  = candidates[i].rdst;
                iss[i].ra1   = candidates[i].ra1;
                iss[i].ra2   = candidates[i].ra2;
                iss[i].rd1   = pick(ops[i].op1, ops[i].rd1);
                iss[i].rd2   = pick(ops[i].op2, ops[i].rd2);
            end
        end
        // younger rides along as the delay slot
        iss[0].is_slot = issue_young && old_is_ctrl;
    end

endmodule

`default_nettype wire

/* source/pair_check.sv */
`default_nettype none

module pair_check (
    input  issue_pkg::dec_pair_t            candidates,
    input  issue_pkg::slot_operands_t [1:0] ops,
    output logic                            issue_old,
    output logic                            issue_young
);

    issue_pkg::dec_entry_t old_c;
    issue_pkg::dec_entry_t young_c;
    logic                  old_ready;
    logic                  young_ready;
    logic                  old_ctrl;
    logic                  young_ctrl;
    logic                  raw_hit;
    logic                  muldiv_hit;
    logic                  hi_hit;
    logic                  lo_hit;
    logic                  hazard;

    assign old_c   = candidates[1];
    assign young_c = candidates[0];

    // both sources present for each slot
    assign old_ready   = ops[1].op1.ready && ops[1].op2.ready;
    assign young_ready = ops[0].op1.ready && ops[0].op2.ready;

    assign old_ctrl   = old_c.ctl.branch || old_c.ctl.jump;
    assign young_ctrl = young_c.ctl.branch || young_c.ctl.jump;

    // branch or jump needs its delay slot ready alongside
    assign issue_old = old_c.valid && old_ready
                    && (!old_ctrl || (young_c.valid && young_ready));

    // read after write between the two
    // a delay slot reads the value from before the branch
    assign raw_hit = old_c.ctl.regwrite && !old_ctrl
                  && (old_c.rdst == young_c.ra1 || old_c.rdst == young_c.ra2);

    // single multiply/divide unit
    assign muldiv_hit = old_c.ctl.muldiv && young_c.ctl.muldiv;

    // hi/lo written then read in the same cycle
    assign hi_hit = old_c.ctl.hiwrite && young_c.ctl.hiread;
    assign lo_hit = old_c.ctl.lowrite && young_c.ctl.loread;

    // any reason to hold the younger back
    // branches only in the older slot, serial ops go alone
    assign hazard = raw_hit
                 || muldiv_hit
                 || hi_hit
                 || lo_hit
                 || young_ctrl
                 || old_c.ctl.serial;

    // in order, younger never overtakes
    assign issue_young = issue_old && young_c.valid && young_ready && !hazard;

endmodule

`default_nettype wire

/* source/issue_top.sv */
`default_nettype none

module issue_top #(
    parameter int QUEUE_DEPTH = 16
) (
    input  logic                            clk,
    input  logic                            arst_n,
    input  logic                            flush,
    input  issue_pkg::dec_pair_t            dec,
    output logic                            dec_ready,
    output issue_pkg::iss_pair_t            iss,
    input  logic                            iss_ready,
    output issue_pkg::src_req_t [1:0]       src,
    input  issue_pkg::slot_operands_t [1:0] ops
);

    localparam int ADDR_W = $clog2(QUEUE_DEPTH);

    // bank write side
    logic                  wr_en_even;
    logic                  wr_en_odd;
    logic [ADDR_W-1:0]     wr_addr_even;
    logic [ADDR_W-1:0]     wr_addr_odd;
    issue_pkg::dec_entry_t wr_data_even;
    issue_pkg::dec_entry_t wr_data_odd;

    // bank read side
    logic [ADDR_W-1:0]     rd_addr_even;
    logic [ADDR_W-1:0]     rd_addr_odd;
    issue_pkg::dec_entry_t rd_data_even;
    issue_pkg::dec_entry_t rd_data_odd;

    // ordering and issue decision
    logic                  older_odd;
    logic                  not_empty_even;
    logic                  not_empty_odd;
    logic                  issue_old;
    logic                  issue_young;
    issue_pkg::dec_pair_t  candidates;

    issue_control #(.QUEUE_DEPTH(QUEUE_DEPTH)) i_issue_control (
        .clk, .arst_n, .flush, .dec, .dec_ready, .iss_ready,
        .issue_old, .issue_young,
        .wr_en_even, .wr_en_odd, .wr_data_even, .wr_data_odd,
        .wr_addr_even, .wr_addr_odd, .rd_addr_even, .rd_addr_odd,
        .older_odd, .not_empty_even, .not_empty_odd
    );

    issue_bank #(.QUEUE_DEPTH(QUEUE_DEPTH)) bank_even (
        .clk, .wr_en(wr_en_even), .wr_addr(wr_addr_even), .wr_data(wr_data_even),
        .rd_addr(rd_addr_even), .rd_data(rd_data_even)
    );

    issue_bank #(.QUEUE_DEPTH(QUEUE_DEPTH)) bank_odd (
        .clk, .wr_en(wr_en_odd), .wr_addr(wr_addr_odd), .wr_data(wr_data_odd),
        .rd_addr(rd_addr_odd), .rd_data(rd_data_odd)
    );

    issue_slots i_issue_slots (
        .rd_data_even, .rd_data_odd, .older_odd, .not_empty_even, .not_empty_odd,
        .issue_old, .issue_young, .ops, .candidates, .src, .iss
    );

    pair_check i_pair_check (
        .candidates, .ops, .issue_old, .issue_young
    );

endmodule

`default_nettype wire

/* verif/issue_properties.sv */
`default_nettype none

module issue_properties #(
    parameter int ADDR_W = 4
) (
    input logic            clk,
    input logic            arst_n,
    input logic            flush,
    input logic            dec_ready,
    input logic [ADDR_W:0] tail_even,
    input logic [ADDR_W:0] tail_odd,
    input logic            not_empty_even,
    input logic            not_empty_odd,
    input logic            older_odd,
    input logic            pop_even,
    input logic            pop_odd
);

    timeunit 1ns;
    timeprecision 100ps;

    // failed assertions so far, read by the testbench top
    int fail_count = 0;

    // back-pressure freezes both tails until decode is let in again
    no_enq_when_full: assert property (@(posedge clk) disable iff (!arst_n)
        (!dec_ready && !flush) |=> ($stable(tail_even) && $stable(tail_odd)))
        else begin
            fail_count++;
            $error("bank written while dec_ready low");
        end

    // reset leaves both banks empty and decode open
    reset_state: assert property (@(posedge clk)
        !arst_n |=> (dec_ready && !not_empty_even && !not_empty_odd))
        else begin
            fail_count++;
            $error("queue not empty or decode blocked after reset");
        end

    // flush empties both banks by the next edge
    flush_empties: assert property (@(posedge clk) disable iff (!arst_n)
        flush |=> (dec_ready && !not_empty_even && !not_empty_odd))
        else begin
            fail_count++;
            $error("queue not empty after flush");
        end

    // in order, a lone pop comes from the bank holding the older entry
    young_needs_old: assert property (@(posedge clk) disable iff (!arst_n)
        (pop_even ^ pop_odd) |-> (pop_odd == older_odd))
        else begin
            fail_count++;
            $error("younger slot issued without the older one");
        end

endmodule

bind issue_control issue_properties #(.ADDR_W(ADDR_W)) i_issue_properties (
    .clk,
    .arst_n,
    .flush,
    .dec_ready,
    .tail_even,
    .tail_odd,
    .not_empty_even,
    .not_empty_odd,
    .older_odd,
    .pop_even,
    .pop_odd
);

`default_nettype wire

/* verif/issue_checker.sv */
`default_nettype none

module issue_checker (
    input  logic                            clk,
    input  logic                            arst_n,
    input  logic                            flush,
    input  issue_pkg::dec_pair_t            dec,
    input  logic                            dec_ready,
    input  issue_pkg::iss_pair_t            iss,
    input  logic                            iss_ready,
    input  issue_pkg::src_req_t [1:0]       src,
    input  issue_pkg::slot_operands_t [1:0] ops,
    output int                              errors,
    output int                              checks,
    output int                              pending
);

    timeunit 1ns;
    timeprecision 100ps;

    // accepted entries, oldest at index 0
    issue_pkg::dec_entry_t model[$];
    issue_pkg::iss_pair_t  expected;
    issue_pkg::dec_entry_t older;
    issue_pkg::dec_entry_t younger;

    // missing entry reads as invalid
    function automatic issue_pkg::dec_entry_t peek(int k);
        if (model.size() > k) begin
            return model[k];
        end
        return '0;
    endfunction

    // queue entry plus its operand values
    function automatic issue_pkg::iss_entry_t to_issued(issue_pkg::dec_entry_t e,
                                                        issue_pkg::slot_operands_t op);
        issue_pkg::iss_entry_t r;
        r = '0;
        r.valid = e.valid;
        r.pc    = e.pc;
        r.imm   = e.imm;
        r.ctl   = e.ctl;
        r.rdst  = e.rdst;
        r.ra1   = e.ra1;
        r.ra2   = e.ra2;
        r.rd1   = op.op1.bypass ? op.op1.data : op.rd1;
        r.rd2   = op.op2.bypass ? op.op2.data : op.rd2;
        return r;
    endfunction

    // expected issue pair for the two oldest entries
    function automatic issue_pkg::iss_pair_t expect_issue(issue_pkg::dec_entry_t o,
                                                          issue_pkg::dec_entry_t y,
                                                          issue_pkg::slot_operands_t [1:0] op);
        issue_pkg::iss_pair_t r;
        logic o_rdy;
        logic y_rdy;
        logic o_cf;
        logic y_cf;
        logic go_old;
        logic blocked;
        r     = '0;
        o_rdy = op[1].op1.ready && op[1].op2.ready;
        y_rdy = op[0].op1.ready && op[0].op2.ready;
        o_cf  = o.ctl.branch || o.ctl.jump;
        y_cf  = y.ctl.branch || y.ctl.jump;
        // control transfer waits for a ready delay slot
        go_old = o.valid && o_rdy && (!o_cf || (y.valid && y_rdy));
        blocked = y_cf || o.ctl.serial
               || (o.ctl.muldiv && y.ctl.muldiv)
               || (o.ctl.hiwrite && y.ctl.hiread)
               || (o.ctl.lowrite && y.ctl.loread)
               || (!o_cf && o.ctl.regwrite && (o.rdst == y.ra1 || o.rdst == y.ra2));
        if (go_old) begin
            r[1] = to_issued(o, op[1]);
            if (y.valid && y_rdy && !blocked) begin
                r[0] = to_issued(y, op[0]);
                r[0].is_slot = o_cf;
            end
        end
        return r;
    endfunction

    always @(posedge clk) begin
        if (arst_n) begin
            older   = peek(0);
            younger = peek(1);
            // lookups follow the two oldest entries
            if (src[1] != {older.ra1, older.ra2} || src[0] != {younger.ra1, younger.ra2}) begin
                errors++;
                $display("error at %0d ns: src %h %h, expected %h %h", $time, src[1], src[0],
                         {older.ra1, older.ra2}, {younger.ra1, younger.ra2});
            end
            if (iss_ready) begin
                expected = expect_issue(older, younger, ops);
                checks++;
                for (int i = 0; i < 2; i++) begin
                    if (iss[i] !== expected[i]) begin
                        errors++;
                        $write("error at %0d ns: slot %0d got v=%b pc=%h rd=%h/%h s=%b,",
                               $time, i, iss[i].valid, iss[i].pc, iss[i].rd1, iss[i].rd2,
                               iss[i].is_slot);
                        $display(" expected v=%b pc=%h rd=%h/%h s=%b",
                                 expected[i].valid, expected[i].pc,
                                 expected[i].rd1, expected[i].rd2, expected[i].is_slot);
                    end
                end
            end
            if (flush) begin
                model.delete();
            end else begin
                // pop what the rules issued, then take new entries
                if (iss_ready && expected[1].valid) begin
                    void'(model.pop_front());
                end
                if (iss_ready && expected[0].valid) begin
                    void'(model.pop_front());
                end
                if (dec_ready && dec[1].valid) begin
                    model.push_back(dec[1]);
                end
                if (dec_ready && dec[0].valid) begin
                    model.push_back(dec[0]);
                end
            end
            pending = model.size();
        end else begin
            model.delete();
            pending = 0;
        end
    end

endmodule

`default_nettype wire

/* verif/issue_tb.sv */
`default_nettype none

module issue_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int DEPTH        = 4;
    localparam int RESET_CYCLES = 5;
    localparam int NUM_TESTS    = 6;
    // longest test drains well inside this
    localparam int TEST_BUDGET  = 200;
    localparam int CYCLE_LIMIT  = RESET_CYCLES + NUM_TESTS * TEST_BUDGET + 100;

    logic                            clk = 1'b0;
    logic                            arst_n;
    logic                            flush;
    issue_pkg::dec_pair_t            dec;
    logic                            dec_ready;
    issue_pkg::iss_pair_t            iss;
    logic                            iss_ready = 1'b0;
    issue_pkg::src_req_t [1:0]       src;
    issue_pkg::slot_operands_t [1:0] ops = '0;

    issue_pkg::slot_operands_t [1:0] ops_nxt;
    logic                            iss_ready_nxt;
    issue_pkg::dec_entry_t           older;
    issue_pkg::dec_entry_t           younger;
    isa_pkg::word_t                  pc_next;
    integer                          seed;
    int                              cycles = 0;
    int                              chk_errors;
    int                              chk_count;
    int                              pending;
    int                              tb_errors;
    int                              prev_errors;
    int                              test_num;
    // 0 ready, 1 random stalls, 2 held low
    int                              stall_mode;
    logic                            ready_rand;
    logic                            dropped;
    int                              accepted;

    issue_top #(.QUEUE_DEPTH(DEPTH)) i_issue_top (
        .clk, .arst_n, .flush, .dec, .dec_ready, .iss, .iss_ready, .src, .ops
    );

    issue_checker i_issue_checker (
        .clk, .arst_n, .flush, .dec, .dec_ready, .iss, .iss_ready, .src, .ops,
        .errors(chk_errors), .checks(chk_count), .pending
    );

    always #4 clk = ~clk;

    // fresh operands each cycle, drawn at the edge and applied just after
    always @(posedge clk) begin
        for (int i = 0; i < 2; i++) begin
            ops_nxt[i].op1.ready  = !ready_rand || (($random(seed) & 3) != 0);
            ops_nxt[i].op2.ready  = !ready_rand || (($random(seed) & 3) != 0);
            ops_nxt[i].op1.bypass = ($random(seed) & 1) != 0;
            ops_nxt[i].op2.bypass = ($random(seed) & 1) != 0;
            ops_nxt[i].op1.data   = $random(seed);
            ops_nxt[i].op2.data   = $random(seed);
            ops_nxt[i].rd1        = $random(seed);
            ops_nxt[i].rd2        = $random(seed);
        end
        iss_ready_nxt = (stall_mode == 0) || (stall_mode == 1 && ($random(seed) & 3) != 0);
        #1;
        ops       = ops_nxt;
        iss_ready = iss_ready_nxt;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Test failed");
            $finish;
        end
    end

    // decoded instruction with flags set from its class
    function automatic issue_pkg::dec_entry_t make_entry(isa_pkg::op_class_t op,
            isa_pkg::reg_addr_t rdst, isa_pkg::reg_addr_t ra1, isa_pkg::reg_addr_t ra2);
        issue_pkg::dec_entry_t e;
        e        = '0;
        e.valid  = 1'b1;
        e.pc     = pc_next;
        e.imm    = pc_next ^ 32'h0000_ffff;
        e.ctl.op = op;
        e.rdst   = rdst;
        e.ra1    = ra1;
        e.ra2    = ra2;
        pc_next  = pc_next + 32'd4;
        case (op)
            isa_pkg::OP_ALU, isa_pkg::OP_LOAD: e.ctl.regwrite = 1'b1;
            isa_pkg::OP_MULDIV: {e.ctl.muldiv, e.ctl.hiwrite, e.ctl.lowrite} = 3'b111;
            isa_pkg::OP_BRANCH: e.ctl.branch = 1'b1;
            // jump and link writes r31
            isa_pkg::OP_JUMP: {e.ctl.jump, e.ctl.regwrite} = 2'b11;
            isa_pkg::OP_EXCEPTION, isa_pkg::OP_ERET: e.ctl.serial = 1'b1;
            isa_pkg::OP_MFHI: {e.ctl.regwrite, e.ctl.hiread} = 2'b11;
            isa_pkg::OP_MFLO: {e.ctl.regwrite, e.ctl.loread} = 2'b11;
            isa_pkg::OP_MTHI: e.ctl.hiwrite = 1'b1;
            isa_pkg::OP_MTLO: e.ctl.lowrite = 1'b1;
            default: ;
        endcase
        return e;
    endfunction

    function automatic int total_errors();
        return chk_errors + tb_errors
             + i_issue_top.i_issue_control.i_issue_properties.fail_count;
    endfunction

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    // offer one pair until decode side takes it
    task automatic send_pair(input issue_pkg::dec_entry_t o, input issue_pkg::dec_entry_t y);
        logic taken;
        taken  = 1'b0;
        dec[1] = o;
        dec[0] = y;
        while (!taken) begin
            @(posedge clk);
            taken = dec_ready;
            #1;
        end
        dec = '0;
    endtask

    task automatic drain();
        while (pending != 0) begin
            idle(1);
        end
        idle(2);
    endtask

    task automatic finish_test(input string name);
        int now;
        now = total_errors();
        test_num++;
        $display("test %0d %s: %0d errors", test_num, name, now - prev_errors);
        prev_errors = now;
    endtask

    initial begin
        seed        = 32'hc99223a6;
        arst_n      = 1'b0;
        flush       = 1'b0;
        dec         = '0;
        pc_next     = 32'h0000_1000;
        tb_errors   = 0;
        prev_errors = 0;
        test_num    = 0;
        stall_mode  = 0;
        ready_rand  = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        arst_n = 1'b1;

        // independent alu pairs
        for (int k = 0; k < 8; k++) begin
            older   = make_entry(isa_pkg::OP_ALU, 5'(16 + 2 * k), 5'(k + 1), 5'(k + 2));
            younger = make_entry(isa_pkg::OP_ALU, 5'(17 + 2 * k), 5'(k + 3), 5'(k + 4));
            send_pair(older, younger);
        end
        drain();
        finish_test("independent pairs");

        // each pair enters an empty queue and splits, younger moves up a cycle later
        older   = make_entry(isa_pkg::OP_ALU, 5'd5, 5'd1, 5'd2);
        younger = make_entry(isa_pkg::OP_ALU, 5'd6, 5'd5, 5'd3);
        send_pair(older, younger);
        drain();
        older   = make_entry(isa_pkg::OP_MULDIV, 5'd0, 5'd1, 5'd2);
        younger = make_entry(isa_pkg::OP_MULDIV, 5'd0, 5'd3, 5'd4);
        send_pair(older, younger);
        drain();
        older   = make_entry(isa_pkg::OP_MTHI, 5'd0, 5'd7, 5'd0);
        younger = make_entry(isa_pkg::OP_MFHI, 5'd8, 5'd0, 5'd0);
        send_pair(older, younger);
        drain();
        older   = make_entry(isa_pkg::OP_MTLO, 5'd0, 5'd7, 5'd0);
        younger = make_entry(isa_pkg::OP_MFLO, 5'd9, 5'd0, 5'd0);
        send_pair(older, younger);
        drain();
        older   = make_entry(isa_pkg::OP_EXCEPTION, 5'd0, 5'd0, 5'd0);
        younger = make_entry(isa_pkg::OP_ALU, 5'd10, 5'd1, 5'd2);
        send_pair(older, younger);
        drain();
        older   = make_entry(isa_pkg::OP_ERET, 5'd0, 5'd0, 5'd0);
        younger = make_entry(isa_pkg::OP_ALU, 5'd11, 5'd1, 5'd2);
        send_pair(older, younger);
        drain();
        finish_test("pairing hazards");

        // lone branch holds until its delay slot arrives
        send_pair(make_entry(isa_pkg::OP_BRANCH, 5'd0, 5'd1, 5'd2), '0);
        idle(4);
        send_pair(make_entry(isa_pkg::OP_ALU, 5'd3, 5'd4, 5'd5), '0);
        // slot reads the link register, no hazard across the jump
        older   = make_entry(isa_pkg::OP_JUMP, 5'd31, 5'd0, 5'd0);
        younger = make_entry(isa_pkg::OP_ALU, 5'd6, 5'd31, 5'd1);
        send_pair(older, younger);
        older   = make_entry(isa_pkg::OP_ALU, 5'd7, 5'd1, 5'd2);
        younger = make_entry(isa_pkg::OP_BRANCH, 5'd0, 5'd7, 5'd3);
        send_pair(older, younger);
        send_pair(make_entry(isa_pkg::OP_ALU, 5'd8, 5'd7, 5'd4), '0);
        drain();
        finish_test("branch delay slot");

        // operands not always ready, random stalls downstream
        ready_rand = 1'b1;
        stall_mode = 1;
        for (int k = 0; k < 10; k++) begin
            older   = make_entry(isa_pkg::op_class_t'(4'($random(seed) & 3)),
                                 5'($random(seed) & 7), 5'($random(seed) & 7), 5'(k));
            younger = make_entry(isa_pkg::op_class_t'(4'($random(seed) & 3)),
                                 5'($random(seed) & 7), 5'($random(seed) & 7), 5'(k));
            send_pair(older, younger);
        end
        drain();
        ready_rand = 1'b0;
        finish_test("operand readiness");

        // fill with issue blocked until decode is held off
        stall_mode = 2;
        dropped    = 1'b0;
        accepted   = 0;
        for (int k = 0; k < 10 && !dropped; k++) begin
            dec[1] = make_entry(isa_pkg::OP_ALU, 5'(k + 12), 5'd1, 5'd2);
            dec[0] = make_entry(isa_pkg::OP_LOAD, 5'(k + 24), 5'd3, 5'd4);
            @(posedge clk);
            dropped = !dec_ready;
            if (!dropped) begin
                accepted++;
            end
            #1;
        end
        dec = '0;
        // one entry per bank per pair, decode stops with one slot left
        if (!dropped) begin
            tb_errors++;
            $display("dec_ready stayed high while iss_ready was held low");
        end else if (accepted != DEPTH - 1) begin
            tb_errors++;
            $display("error at %0d ns: decode held off after %0d pairs, expected %0d",
                     $time, accepted, DEPTH - 1);
        end
        stall_mode = 1;
        drain();
        finish_test("back-pressure");

        // queued entries are discarded by the flush
        stall_mode = 2;
        send_pair(make_entry(isa_pkg::OP_ALU, 5'd1, 5'd2, 5'd3),
                  make_entry(isa_pkg::OP_ALU, 5'd4, 5'd5, 5'd6));
        send_pair(make_entry(isa_pkg::OP_MULDIV, 5'd0, 5'd2, 5'd3), '0);
        flush  = 1'b1;
        dec[1] = make_entry(isa_pkg::OP_ALU, 5'd9, 5'd2, 5'd3);
        idle(1);
        flush = 1'b0;
        dec   = '0;
        stall_mode = 0;
        idle(3);
        stall_mode = 1;
        for (int k = 0; k < 3; k++) begin
            older   = make_entry(isa_pkg::OP_ALU, 5'(20 + k), 5'd1, 5'd2);
            younger = make_entry(isa_pkg::OP_STORE, 5'd0, 5'd3, 5'(20 + k));
            send_pair(older, younger);
        end
        drain();
        finish_test("flush");

        $display("%0d tests, %0d checks, %0d errors", test_num, chk_count, total_errors());
        if (total_errors() == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* all.f */
source/isa_pkg.sv
source/issue_pkg.sv
source/issue_bank.sv
source/issue_control.sv
source/issue_slots.sv
source/pair_check.sv
source/issue_top.sv
verif/issue_properties.sv
verif/issue_checker.sv
verif/issue_tb.sv

/* Makefile */
TOP := issue_tb

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): all.f source/*.sv verif/*.sv
	verilator --binary --assert -j 0 --top-module $(TOP) -f all.f

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	@if grep -q "Test failed" sim.log; then echo "simulation failed"; exit 1; fi
	@if ! grep -q "Test passed" sim.log; then echo "simulation ended early"; exit 1; fi

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f all.f

clean:
	rm -rf obj_dir sim.log
